// ==== list.f ====
source/rvPkg.sv
source/fetchStage.sv
source/decodeStage.sv
source/regFile.sv
source/executeStage.sv
source/memStage.sv
source/rvCore.sv
verif/rvCoreTb.sv

// ==== Bender.yml ====
package:
  name: rvCore

sources:
  - source/rvPkg.sv
  - source/fetchStage.sv
  - source/decodeStage.sv
  - source/regFile.sv
  - source/executeStage.sv
  - source/memStage.sv
  - source/rvCore.sv
  - target: test
    files:
      - verif/rvCoreTb.sv

// ==== verif/rvCoreTb.sv ====
`timescale 1ns/1ps

module rvCoreTb;

	localparam int ImemDepth = 128;
	localparam int DmemDepth = 256;
	localparam int ProgLen = 110;
	localparam int NumRetires = 160;
	localparam int RetireTimeout = 400;

	// RV32I major opcodes
	localparam logic [6:0] OpcLui = 7'h37;
	localparam logic [6:0] OpcAuipc = 7'h17;
	localparam logic [6:0] OpcJal = 7'h6f;
	localparam logic [6:0] OpcJalr = 7'h67;
	localparam logic [6:0] OpcBranch = 7'h63;
	localparam logic [6:0] OpcLoad = 7'h03;
	localparam logic [6:0] OpcStore = 7'h23;
	localparam logic [6:0] OpcImm = 7'h13;
	localparam logic [6:0] OpcReg = 7'h33;

	logic        clk;
	logic        rst;
	logic        run;
	logic        imemWe;
	logic [8:0]  imemAddr;
	logic [31:0] imemData;
	logic        retireValid;
	logic [31:0] retirePc;
	logic [4:0]  retireRd;
	logic        retireWe;
	logic [31:0] retireData;

	int          seed = 45;
	int          cyc = 0;
	int          runCyc = 0;
	logic        runHigh = 1'b0;
	logic        retiresDone = 1'b0;
	logic [31:0] prog [ImemDepth];

	// model state
	logic [31:0] mPc;
	logic [31:0] mRegs [32];
	logic [7:0]  mBytes [4 * DmemDepth];

	rvCore #(.ImemDepth(ImemDepth), .DmemDepth(DmemDepth)) u_rvCore (
		.clk(clk), .rst(rst), .run_i(run),
		.imemWe_i(imemWe), .imemAddr_i(imemAddr), .imemData_i(imemData),
		.retireValid_o(retireValid), .retirePc_o(retirePc), .retireRd_o(retireRd),
		.retireWe_o(retireWe), .retireData_o(retireData)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OpcReg};
	endfunction

	function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OpcStore};
	endfunction

	function automatic logic [31:0] bType(input logic [12:0] off, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OpcBranch};
	endfunction

	function automatic logic [31:0] jType(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, OpcJal};
	endfunction

	// random program, all control transfers go forward and end in a self loop
	task automatic buildProgram();
		int i;
		int kind;
		int span;
		int tgt;
		int sz;
		logic [31:0] word;
		logic [11:0] imm;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		for (i = 0; i < ImemDepth; i++) begin
			prog[i] = iType(12'(i), 5'd0, 3'd0, 5'd0, OpcImm);
		end
		// zero the data area that loads touch
		for (i = 0; i < 16; i++) begin
			prog[i] = sType(12'(4 * i), 5'd0, 5'd0, 3'b010);
		end
		i = 16;
		while (i < ProgLen) begin
			word = $random(seed);
			imm = word[31:20];
			rd = word[4:0];
			rs1 = word[9:5];
			rs2 = word[14:10];
			f3 = word[17:15];
			kind = {$random(seed)} % 8;
			span = (ProgLen - i > 8) ? 8 : ProgLen - i;
			tgt = i + 1 + {$random(seed)} % span;
			sz = {$random(seed)} % 3;
			case (kind)
				0: prog[i] = rType(((f3 == 3'd0 || f3 == 3'd5) && imm[0]) ? 7'h20 : 7'h00,
					rs2, rs1, f3, rd);
				1: begin
					if (f3 == 3'd1 || f3 == 3'd5) begin
						imm = {(f3 == 3'd5 && imm[11]) ? 7'h20 : 7'h00, imm[4:0]};
					end
					prog[i] = iType(imm, rs1, f3, rd, OpcImm);
				end
				2: prog[i] = {word[19:0] ^ 20'(word[31:12]), rd, imm[0] ? OpcLui : OpcAuipc};
				3: prog[i] = sType(12'(({$random(seed)} % 64) & ~((1 << sz) - 1)), rs2,
					5'd0, 3'(sz));
				4: begin
					sz = {$random(seed)} % 5;
					f3 = (sz < 3) ? 3'(sz) : 3'(sz + 1);
					prog[i] = iType(12'(({$random(seed)} % 64) & ~((1 << f3[1:0]) - 1)),
						5'd0, f3, rd, OpcLoad);
				end
				5: begin
					sz = {$random(seed)} % 6;
					f3 = (sz < 2) ? 3'(sz) : 3'(sz + 2);
					prog[i] = bType(13'((tgt - i) * 4), rs2, rs1, f3);
				end
				6: prog[i] = jType(21'((tgt - i) * 4), rd);
				default: begin
					if (i + 1 < ProgLen) begin
						span = (ProgLen - i - 1 > 8) ? 8 : ProgLen - i - 1;
						tgt = i + 2 + {$random(seed)} % span;
						// base in x31, odd offset checks that bit 0 is cleared
						prog[i] = iType(12'(tgt * 4), 5'd0, 3'd0, 5'd31, OpcImm);
						prog[i + 1] = iType({11'b0, imm[0]}, 5'd31, 3'd0, rd, OpcJalr);
						i++;
					end else begin
						prog[i] = iType(12'd0, 5'd0, 3'd0, 5'd0, OpcImm);
					end
				end
			endcase
			i++;
		end
		prog[ProgLen] = jType(21'd0, 5'd0);
	endtask

	function automatic logic [31:0] aluCalc(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: begin
				if (alt) begin
					return $signed(a) >>> b[4:0];
				end
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// steps the model by one instruction and gives the retire it expects
	function automatic void refStep(input logic [31:0] ins, output logic [31:0] expPc,
			output logic [4:0] expRd, output logic expWe, output logic [31:0] expData);
		logic [2:0]  f3;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] immB;
		logic [31:0] immJ;
		logic [31:0] addr;
		logic [31:0] nextPc;
		logic [9:0]  at;
		logic        take;
		f3 = ins[14:12];
		a = mRegs[ins[19:15]];
		b = mRegs[ins[24:20]];
		immI = {{20{ins[31]}}, ins[31:20]};
		immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		expPc = mPc;
		expRd = ins[11:7];
		expWe = 1'b1;
		expData = '0;
		nextPc = mPc + 32'd4;
		case (ins[6:0])
			OpcLui: expData = {ins[31:12], 12'b0};
			OpcAuipc: expData = mPc + {ins[31:12], 12'b0};
			OpcJal: begin
				expData = mPc + 32'd4;
				nextPc = mPc + immJ;
			end
			OpcJalr: begin
				expData = mPc + 32'd4;
				nextPc = (a + immI) & ~32'd1;
			end
			OpcBranch: begin
				expWe = 1'b0;
				case (f3)
					3'd0: take = (a == b);
					3'd1: take = (a != b);
					3'd4: take = ($signed(a) < $signed(b));
					3'd5: take = ($signed(a) >= $signed(b));
					3'd6: take = (a < b);
					default: take = (a >= b);
				endcase
				if (take) begin
					nextPc = mPc + immB;
				end
			end
			OpcLoad: begin
				addr = a + immI;
				at = addr[9:0];
				case (f3)
					3'd0: expData = {{24{mBytes[at][7]}}, mBytes[at]};
					3'd1: expData = {{16{mBytes[at + 1][7]}}, mBytes[at + 1], mBytes[at]};
					3'd4: expData = {24'b0, mBytes[at]};
					3'd5: expData = {16'b0, mBytes[at + 1], mBytes[at]};
					default: expData = {mBytes[at + 3], mBytes[at + 2], mBytes[at + 1],
						mBytes[at]};
				endcase
			end
			OpcStore: begin
				expWe = 1'b0;
				addr = a + immS;
				at = addr[9:0];
				for (int k = 0; k < (1 << f3[1:0]); k++) begin
					mBytes[at + k] = b[8*k +: 8];
				end
			end
			OpcImm: expData = aluCalc(f3, ins[30] && f3 == 3'd5, a, immI);
			OpcReg: expData = aluCalc(f3, ins[30], a, b);
			default: expWe = 1'b0;
		endcase
		if (expWe && expRd != 5'd0) begin
			mRegs[expRd] = expData;
		end
		mPc = nextPc;
	endfunction

	task automatic checkField(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic waitRetire();
		int waited;
		waited = 0;
		@(negedge clk);
		while (retireValid !== 1'b1) begin
			if (!runHigh) begin
				checkField("write-back while run_i low", retireWe, 1'b0);
			end
			waited++;
			if (waited > RetireTimeout) begin
				$display("timeout: no retire strobe arrived within %0d cycles", RetireTimeout);
				$display("TEST FAILED");
				$fatal(1);
			end
			@(negedge clk);
		end
		checkField("run_i high at retire", runHigh, 1'b1);
	endtask

	initial begin : compareRetires
		logic [31:0] expPc;
		logic [31:0] expData;
		logic [4:0]  expRd;
		logic        expWe;
		int          lastCyc;
		mPc = '0;
		for (int r = 0; r < 32; r++) begin
			mRegs[r] = '0;
		end
		for (int k = 0; k < 4 * DmemDepth; k++) begin
			mBytes[k] = '0;
		end
		lastCyc = 0;
		for (int n = 0; n < NumRetires; n++) begin
			waitRetire();
			if (n == 0) begin
				checkField("cycles from run to first retire", cyc - runCyc, 32'd4);
			end else begin
				checkField("cycles between retires", cyc - lastCyc, 32'd5);
			end
			lastCyc = cyc;
			refStep(prog[mPc[8:2]], expPc, expRd, expWe, expData);
			checkField("retire pc", retirePc, expPc);
			checkField("retire write enable", retireWe, expWe);
			if (expWe) begin
				checkField("retire rd", retireRd, expRd);
				checkField("retire data", retireData, expData);
			end
		end
		retiresDone = 1'b1;
	end

	initial begin : mainFlow
		int waited;
		int extra;
		rst = 1'b1;
		run = 1'b0;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		buildProgram();
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		// program load while the core sits idle
		for (int i = 0; i < ImemDepth; i++) begin
			@(posedge clk);
			#1;
			imemWe = 1'b1;
			imemAddr = 9'(i);
			imemData = prog[i];
		end
		@(posedge clk);
		#1;
		imemWe = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		runCyc = cyc;
		runHigh = 1'b1;
		run = 1'b1;
		waited = 0;
		while (!retiresDone) begin
			@(posedge clk);
			waited++;
			if (waited > NumRetires * 5 + 50) begin
				$display("timeout: the core did not reach %0d retires", NumRetires);
				$display("TEST FAILED");
				$fatal(1);
			end
		end
		// the next fetch issues on this edge, so one instruction is in flight
		@(posedge clk);
		#1;
		run = 1'b0;
		// only the instruction in flight still retires
		extra = 0;
		repeat (30) begin
			@(negedge clk);
			if (retireValid === 1'b1) begin
				extra++;
			end
		end
		if (extra == 1) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			$display("error at %0t ns: %0d retires after run_i went low", $time, extra);
			$display("TEST FAILED");
			$fatal(1);
		end
	end

endmodule

// ==== source/rvCore.sv ====
`timescale 1ns/1ps

module rvCore #(
	parameter int ImemDepth = 128,
	parameter int DmemDepth = 256
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        run_i,
	input  logic        imemWe_i,
	input  logic [8:0]  imemAddr_i,
	input  logic [31:0] imemData_i,
	output logic        retireValid_o,
	output logic [31:0] retirePc_o,
	output logic [4:0]  retireRd_o,
	output logic        retireWe_o,
	output logic [31:0] retireData_o
);

	import rvPkg::*;

	logic        fetchValid;
	logic [31:0] fetchPc, instr;
	logic [4:0]  rs1Addr, rs2Addr;
	logic [31:0] rs1Data, rs2Data;

	logic        decValid, aSelPc, bSelImm, brUnsigned, isBranch, isJal, isJalr;
	logic        decMemWe, decMemRe, decRegWe;
	logic [31:0] decPc, decImm;
	logic [4:0]  decRd;
	logic [2:0]  decFunct3;
	AluOpT       decAluOp;
	SizeT        decSize;
	WbSelT       decWbSel;

	logic        exValid, exMemWe, exMemRe, exRegWe, branchTaken;
	logic [31:0] aluResult, storeData, pcPlus4, nextPc;
	logic [4:0]  exRd;
	SizeT        exSize;
	WbSelT       exWbSel;

	logic        wrEn;
	logic [4:0]  wrAddr;
	logic [31:0] wrData;

	fetchStage #(.ImemDepth(ImemDepth)) u_fetchStage (
		.clk(clk), .rst(rst), .run_i(run_i),
		.imemWe_i(imemWe_i), .imemAddr_i(imemAddr_i), .imemData_i(imemData_i),
		.retireValid_i(retireValid_o), .branchTaken_i(branchTaken), .nextPc_i(nextPc),
		.fetchValid_o(fetchValid), .pc_o(fetchPc), .instr_o(instr)
	);

	decodeStage u_decodeStage (
		.clk(clk), .rst(rst), .fetchValid_i(fetchValid), .pc_i(fetchPc), .instr_i(instr),
		.rs1Addr_o(rs1Addr), .rs2Addr_o(rs2Addr), .decValid_o(decValid),
		.pc_o(decPc), .rd_o(decRd), .imm_o(decImm), .aluOp_o(decAluOp),
		.aSelPc_o(aSelPc), .bSelImm_o(bSelImm), .brUnsigned_o(brUnsigned),
		.isBranch_o(isBranch), .isJal_o(isJal), .isJalr_o(isJalr), .funct3_o(decFunct3),
		.memWe_o(decMemWe), .memRe_o(decMemRe), .size_o(decSize), .wbSel_o(decWbSel),
		.regWe_o(decRegWe)
	);

	regFile u_regFile (
		.clk(clk), .rst(rst), .rs1Addr_i(rs1Addr), .rs2Addr_i(rs2Addr),
		.rs1Data_o(rs1Data), .rs2Data_o(rs2Data),
		.wrEn_i(wrEn), .wrAddr_i(wrAddr), .wrData_i(wrData)
	);

	executeStage u_executeStage (
		.clk(clk), .rst(rst), .decValid_i(decValid), .pc_i(decPc), .rd_i(decRd),
		.imm_i(decImm), .aluOp_i(decAluOp), .aSelPc_i(aSelPc), .bSelImm_i(bSelImm),
		.brUnsigned_i(brUnsigned), .isBranch_i(isBranch), .isJal_i(isJal),
		.isJalr_i(isJalr), .funct3_i(decFunct3), .memWe_i(decMemWe), .memRe_i(decMemRe),
		.size_i(decSize), .wbSel_i(decWbSel), .regWe_i(decRegWe),
		.rs1Data_i(rs1Data), .rs2Data_i(rs2Data),
		.exValid_o(exValid), .aluResult_o(aluResult), .storeData_o(storeData),
		.pcPlus4_o(pcPlus4), .rd_o(exRd), .memWe_o(exMemWe), .memRe_o(exMemRe),
		.size_o(exSize), .wbSel_o(exWbSel), .regWe_o(exRegWe),
		.branchTaken_o(branchTaken), .nextPc_o(nextPc)
	);

	memStage #(.DmemDepth(DmemDepth)) u_memStage (
		.clk(clk), .rst(rst), .exValid_i(exValid), .aluResult_i(aluResult),
		.storeData_i(storeData), .pcPlus4_i(pcPlus4), .rd_i(exRd),
		.memWe_i(exMemWe), .memRe_i(exMemRe), .size_i(exSize), .wbSel_i(exWbSel),
		.regWe_i(exRegWe), .wrEn_o(wrEn), .wrAddr_o(wrAddr), .wrData_o(wrData),
		.retireValid_o(retireValid_o), .retirePc_o(retirePc_o), .retireRd_o(retireRd_o),
		.retireData_o(retireData_o), .retireWe_o(retireWe_o)
	);

endmodule

// ==== source/memStage.sv ====
`timescale 1ns/1ps

module memStage #(
	parameter int DmemDepth = 256
) (
	input  logic          clk,
	input  logic          rst,
	input  logic          exValid_i,
	input  logic [31:0]   aluResult_i,
	input  logic [31:0]   storeData_i,
	input  logic [31:0]   pcPlus4_i,
	input  logic [4:0]    rd_i,
	input  logic          memWe_i,
	input  logic          memRe_i,
	input  rvPkg::SizeT   size_i,
	input  rvPkg::WbSelT  wbSel_i,
	input  logic          regWe_i,
	output logic          wrEn_o,
	output logic [4:0]    wrAddr_o,
	output logic [31:0]   wrData_o,
	output logic          retireValid_o,
	output logic [31:0]   retirePc_o,
	output logic [4:0]    retireRd_o,
	output logic [31:0]   retireData_o,
	output logic          retireWe_o
);

	import rvPkg::*;

	localparam int AddrW = $clog2(DmemDepth);

	logic [31:0] dmem [DmemDepth];
	logic [31:0] addrQ, storeQ, pcPlus4Q, rdWord;
	logic [31:0] shifted, loadData, laneData;
	logic [4:0]  rdQ;
	logic [3:0]  byteEn;
	logic        memWeQ, regWeQ;
	SizeT        sizeQ;
	WbSelT       wbSelQ;

	always_ff @(posedge clk) begin
		if (rst) begin
			retireValid_o <= 1'b0;
			memWeQ <= 1'b0;
			regWeQ <= 1'b0;
		end else begin
			retireValid_o <= exValid_i;
			memWeQ <= exValid_i && memWe_i;
			regWeQ <= exValid_i && regWe_i;
		end
	end

	always_ff @(posedge clk) begin
		if (exValid_i) begin
			addrQ <= aluResult_i;
			storeQ <= storeData_i;
			pcPlus4Q <= pcPlus4_i;
			rdQ <= rd_i;
			sizeQ <= size_i;
			wbSelQ <= wbSel_i;
		end
		// synchronous read, address wraps over the array
		if (exValid_i && memRe_i) begin
			rdWord <= dmem[aluResult_i[AddrW+1:2]];
		end
	end

	// store lanes by size and low address bits
	always_comb begin
		case (sizeQ[1:0])
			2'b00: begin
				byteEn = 4'b0001 << addrQ[1:0];
				laneData = {4{storeQ[7:0]}};
			end
			2'b01: begin
				byteEn = 4'b0011 << {addrQ[1], 1'b0};
				laneData = {2{storeQ[15:0]}};
			end
			default: begin
				byteEn = 4'b1111;
				laneData = storeQ;
			end
		endcase
	end

	// store lands on the same edge as the register write
	always_ff @(posedge clk) begin
		if (retireValid_o && memWeQ) begin
			for (int i = 0; i < 4; i++) begin
				if (byteEn[i]) begin
					dmem[addrQ[AddrW+1:2]][8*i +: 8] <= laneData[8*i +: 8];
				end
			end
		end
	end

	assign shifted = rdWord >> {addrQ[1:0], 3'b000};

	always_comb begin
		case (sizeQ)
			SizeB:   loadData = {{24{shifted[7]}}, shifted[7:0]};
			SizeBu:  loadData = {24'b0, shifted[7:0]};
			SizeH:   loadData = {{16{shifted[15]}}, shifted[15:0]};
			SizeHu:  loadData = {16'b0, shifted[15:0]};
			default: loadData = shifted;
		endcase
	end

	always_comb begin
		case (wbSelQ)
			WbLoad:  wrData_o = loadData;
			WbPc4:   wrData_o = pcPlus4Q;
			default: wrData_o = addrQ;
		endcase
	end

	assign wrEn_o = retireValid_o && regWeQ;
	assign wrAddr_o = rdQ;
	assign retirePc_o = pcPlus4Q - 32'd4;
	assign retireRd_o = rdQ;
	assign retireData_o = wrData_o;
	assign retireWe_o = wrEn_o;

	// address comes from the execute ALU, size from decode
	assert property (@(posedge clk) disable iff (rst)
		exValid_i && (memWe_i || memRe_i) |->
		!(size_i[0] && aluResult_i[0]) && !(size_i[1] && |aluResult_i[1:0]))
		else $error("misaligned halfword or word access");

endmodule

// ==== source/executeStage.sv ====
`timescale 1ns/1ps

module executeStage (
	input  logic          clk,
	input  logic          rst,
	input  logic          decValid_i,
	input  logic [31:0]   pc_i,
	input  logic [4:0]    rd_i,
	input  logic [31:0]   imm_i,
	input  rvPkg::AluOpT  aluOp_i,
	input  logic          aSelPc_i,
	input  logic          bSelImm_i,
	input  logic          brUnsigned_i,
	input  logic          isBranch_i,
	input  logic          isJal_i,
	input  logic          isJalr_i,
	input  logic [2:0]    funct3_i,
	input  logic          memWe_i,
	input  logic          memRe_i,
	input  rvPkg::SizeT   size_i,
	input  rvPkg::WbSelT  wbSel_i,
	input  logic          regWe_i,
	input  logic [31:0]   rs1Data_i,
	input  logic [31:0]   rs2Data_i,
	output logic          exValid_o,
	output logic [31:0]   aluResult_o,
	output logic [31:0]   storeData_o,
	output logic [31:0]   pcPlus4_o,
	output logic [4:0]    rd_o,
	output logic          memWe_o,
	output logic          memRe_o,
	output rvPkg::SizeT   size_o,
	output rvPkg::WbSelT  wbSel_o,
	output logic          regWe_o,
	output logic          branchTaken_o,
	output logic [31:0]   nextPc_o
);

	import rvPkg::*;

	logic [31:0] opA;
	logic [31:0] opB;
	logic [31:0] aluOut;
	logic        regEq;
	logic        regLt;
	logic        take;

	// operand select, pc for auipc, jal and branch targets
	assign opA = aSelPc_i ? pc_i : rs1Data_i;
	assign opB = bSelImm_i ? imm_i : rs2Data_i;

	always_comb begin
		case (aluOp_i)
			AluAdd:  aluOut = opA + opB;
			AluSub:  aluOut = opA - opB;
			AluSll:  aluOut = opA << opB[4:0];
			AluSlt:  aluOut = {31'b0, $signed(opA) < $signed(opB)};
			AluSltu: aluOut = {31'b0, opA < opB};
			AluXor:  aluOut = opA ^ opB;
			AluSrl:  aluOut = opA >> opB[4:0];
			AluSra:  aluOut = $signed(opA) >>> opB[4:0];
			AluOr:   aluOut = opA | opB;
			AluAnd:  aluOut = opA & opB;
			default: aluOut = opB;
		endcase
	end

	// branch comparator on the register operands
	assign regEq = rs1Data_i == rs2Data_i;
	assign regLt = brUnsigned_i ? (rs1Data_i < rs2Data_i)
		: ($signed(rs1Data_i) < $signed(rs2Data_i));

	always_comb begin
		case (funct3_i)
			3'b000: take = regEq;
			3'b001: take = !regEq;
			3'b100, 3'b110: take = regLt;
			default: take = !regLt;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			exValid_o <= 1'b0;
			memWe_o <= 1'b0;
			memRe_o <= 1'b0;
			regWe_o <= 1'b0;
			branchTaken_o <= 1'b0;
		end else begin
			exValid_o <= decValid_i;
			if (decValid_i) begin
				memWe_o <= memWe_i;
				memRe_o <= memRe_i;
				regWe_o <= regWe_i;
				branchTaken_o <= isJal_i || isJalr_i || (isBranch_i && take);
			end
		end
	end

	// held until the next instruction, fetch reads it at retire
	always_ff @(posedge clk) begin
		if (decValid_i) begin
			aluResult_o <= aluOut;
			storeData_o <= rs2Data_i;
			pcPlus4_o <= pc_i + 32'd4;
			rd_o <= rd_i;
			size_o <= size_i;
			wbSel_o <= wbSel_i;
			nextPc_o <= isJalr_i ? {aluOut[31:1], 1'b0} : aluOut;
		end
	end

endmodule

// ==== source/regFile.sv ====
`timescale 1ns/1ps

module regFile (
	input  logic        clk,
	input  logic        rst,
	input  logic [4:0]  rs1Addr_i,
	input  logic [4:0]  rs2Addr_i,
	output logic [31:0] rs1Data_o,
	output logic [31:0] rs2Data_o,
	input  logic        wrEn_i,
	input  logic [4:0]  wrAddr_i,
	input  logic [31:0] wrData_i
);

	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn_i && wrAddr_i != 5'd0) begin
			regs[wrAddr_i] <= wrData_i;
		end
	end

	// x0 never written, still forced to zero on read
	always_ff @(posedge clk) begin
		rs1Data_o <= (rs1Addr_i == 5'd0) ? '0 : regs[rs1Addr_i];
		rs2Data_o <= (rs2Addr_i == 5'd0) ? '0 : regs[rs2Addr_i];
	end

endmodule

// ==== source/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage (
	input  logic          clk,
	input  logic          rst,
	input  logic          fetchValid_i,
	input  logic [31:0]   pc_i,
	input  logic [31:0]   instr_i,
	output logic [4:0]    rs1Addr_o,
	output logic [4:0]    rs2Addr_o,
	output logic          decValid_o,
	output logic [31:0]   pc_o,
	output logic [4:0]    rd_o,
	output logic [31:0]   imm_o,
	output rvPkg::AluOpT  aluOp_o,
	output logic          aSelPc_o,
	output logic          bSelImm_o,
	output logic          brUnsigned_o,
	output logic          isBranch_o,
	output logic          isJal_o,
	output logic          isJalr_o,
	output logic [2:0]    funct3_o,
	output logic          memWe_o,
	output logic          memRe_o,
	output rvPkg::SizeT   size_o,
	output rvPkg::WbSelT  wbSel_o,
	output logic          regWe_o
);

	import rvPkg::*;

	InstrU instr;
	logic [31:0] immD;
	AluOpT aluOpD;
	WbSelT wbSelD;
	logic aSelPcD, bSelImmD, isBranchD, isJalD, isJalrD;
	logic memWeD, memReD, regWeD;

	function automatic AluOpT aluFromFunct3(input logic [2:0] funct3, input logic alt);
		case (funct3)
			3'b000: return alt ? AluSub : AluAdd;
			3'b001: return AluSll;
			3'b010: return AluSlt;
			3'b011: return AluSltu;
			3'b100: return AluXor;
			3'b101: return alt ? AluSra : AluSrl;
			3'b110: return AluOr;
			default: return AluAnd;
		endcase
	endfunction

	assign instr = instr_i;
	// register file reads on the same edge as the decode registers
	assign rs1Addr_o = instr.r.rs1;
	assign rs2Addr_o = instr.r.rs2;

	always_comb begin
		immD = {{20{instr.i.imm11_0[11]}}, instr.i.imm11_0};
		aluOpD = AluAdd;
		wbSelD = WbAlu;
		aSelPcD = 1'b0;
		bSelImmD = 1'b1;
		isBranchD = 1'b0;
		isJalD = 1'b0;
		isJalrD = 1'b0;
		memWeD = 1'b0;
		memReD = 1'b0;
		regWeD = 1'b0;
		case (instr.r.opcode)
			OpLui: begin
				immD = {instr.u.imm31_12, 12'b0};
				aluOpD = AluPassB;
				regWeD = 1'b1;
			end
			OpAuipc: begin
				immD = {instr.u.imm31_12, 12'b0};
				aSelPcD = 1'b1;
				regWeD = 1'b1;
			end
			OpJal: begin
				immD = {{12{instr.j.imm20}}, instr.j.imm19_12, instr.j.imm11,
					instr.j.imm10_1, 1'b0};
				aSelPcD = 1'b1;
				isJalD = 1'b1;
				wbSelD = WbPc4;
				regWeD = 1'b1;
			end
			OpJalr: begin
				isJalrD = 1'b1;
				wbSelD = WbPc4;
				regWeD = 1'b1;
			end
			OpBranch: begin
				immD = {{20{instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5,
					instr.b.imm4_1, 1'b0};
				aSelPcD = 1'b1;
				isBranchD = 1'b1;
			end
			OpLoad: begin
				memReD = 1'b1;
				wbSelD = WbLoad;
				regWeD = 1'b1;
			end
			OpStore: begin
				immD = {{20{instr.s.imm11_5[6]}}, instr.s.imm11_5, instr.s.imm4_0};
				memWeD = 1'b1;
			end
			OpImm: begin
				// only shifts use funct7, addi never becomes sub
				aluOpD = aluFromFunct3(instr.i.funct3,
					instr.r.funct7[5] && instr.i.funct3 == 3'b101);
				regWeD = 1'b1;
			end
			OpReg: begin
				aluOpD = aluFromFunct3(instr.r.funct3, instr.r.funct7[5]);
				bSelImmD = 1'b0;
				regWeD = 1'b1;
			end
			// fence, system and unknown opcodes fall through as no-ops
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			decValid_o <= 1'b0;
			memWe_o <= 1'b0;
			memRe_o <= 1'b0;
			regWe_o <= 1'b0;
		end else begin
			decValid_o <= fetchValid_i;
			if (fetchValid_i) begin
				memWe_o <= memWeD;
				memRe_o <= memReD;
				regWe_o <= regWeD;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fetchValid_i) begin
			pc_o <= pc_i;
			rd_o <= instr.r.rd;
			imm_o <= immD;
			aluOp_o <= aluOpD;
			aSelPc_o <= aSelPcD;
			bSelImm_o <= bSelImmD;
			brUnsigned_o <= instr.b.funct3[1];
			isBranch_o <= isBranchD;
			isJal_o <= isJalD;
			isJalr_o <= isJalrD;
			funct3_o <= instr.r.funct3;
			size_o <= SizeT'(instr.r.funct3);
			wbSel_o <= wbSelD;
		end
	end

	// fetch strobe is a single pulse and decode answers it next cycle
	assert property (@(posedge clk) disable iff (rst)
		fetchValid_i |=> decValid_o && !fetchValid_i)
		else $error("decode strobe did not follow a single fetch strobe");

endmodule

// ==== source/fetchStage.sv ====
`timescale 1ns/1ps

module fetchStage #(
	parameter int ImemDepth = 128
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        run_i,
	input  logic        imemWe_i,
	input  logic [8:0]  imemAddr_i,
	input  logic [31:0] imemData_i,
	input  logic        retireValid_i,
	input  logic        branchTaken_i,
	input  logic [31:0] nextPc_i,
	output logic        fetchValid_o,
	output logic [31:0] pc_o,
	output logic [31:0] instr_o
);

	localparam int AddrW = $clog2(ImemDepth);

	logic [31:0] imem [ImemDepth];
	logic [31:0] pc;
	logic        busy;
	logic        issue;

	// one instruction in flight, so a new fetch waits for retire
	assign issue = !busy && run_i;
	assign pc_o = pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			busy <= 1'b0;
			fetchValid_o <= 1'b0;
		end else begin
			fetchValid_o <= issue;
			if (issue) begin
				busy <= 1'b1;
			end else if (retireValid_i) begin
				busy <= 1'b0;
				pc <= branchTaken_i ? nextPc_i : pc + 32'd4;
			end
		end
	end

	// load port and synchronous instruction read
	always_ff @(posedge clk) begin
		if (imemWe_i) begin
			imem[imemAddr_i[AddrW-1:0]] <= imemData_i;
		end
		if (issue) begin
			instr_o <= imem[pc[AddrW+1:2]];
		end
	end

	// program loading only between instructions
	assert property (@(posedge clk) disable iff (rst) busy |-> !imemWe_i)
		else $error("instruction memory written while an instruction is in flight");

endmodule

// ==== source/rvPkg.sv ====
package rvPkg;

	// RV32I major opcodes
	typedef enum logic [6:0] {
		OpLui     = 7'b0110111,
		OpAuipc   = 7'b0010111,
		OpJal     = 7'b1101111,
		OpJalr    = 7'b1100111,
		OpBranch  = 7'b1100011,
		OpLoad    = 7'b0000011,
		OpStore   = 7'b0100011,
		OpImm     = 7'b0010011,
		OpReg     = 7'b0110011,
		OpSystem  = 7'b1110011,
		OpMiscMem = 7'b0001111
	} OpcodeT;

	typedef enum logic [3:0] {
		AluAdd,
		AluSub,
		AluSll,
		AluSlt,
		AluSltu,
		AluXor,
		AluSrl,
		AluSra,
		AluOr,
		AluAnd,
		AluPassB
	} AluOpT;

	typedef enum logic [1:0] {
		WbAlu,
		WbLoad,
		WbPc4
	} WbSelT;

	// same encoding as funct3 of loads and stores
	typedef enum logic [2:0] {
		SizeB  = 3'b000,
		SizeH  = 3'b001,
		SizeW  = 3'b010,
		SizeBu = 3'b100,
		SizeHu = 3'b101
	} SizeT;

	// one instruction word, six ways to slice it
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			OpcodeT     opcode;
		} r;
		struct packed {
			logic [11:0] imm11_0;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			OpcodeT      opcode;
		} i;
		struct packed {
			logic [6:0] imm11_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm4_0;
			OpcodeT     opcode;
		} s;
		struct packed {
			logic       imm12;
			logic [5:0] imm10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4_1;
			logic       imm11;
			OpcodeT     opcode;
		} b;
		struct packed {
			logic [19:0] imm31_12;
			logic [4:0]  rd;
			OpcodeT      opcode;
		} u;
		struct packed {
			logic       imm20;
			logic [9:0] imm10_1;
			logic       imm11;
			logic [7:0] imm19_12;
			logic [4:0] rd;
			OpcodeT     opcode;
		} j;
	} InstrU;

endpackage
